// File: design/lcd_timing_pkg.sv
package lcd_timing_pkg;

    // 8080 write strobe phases, in pclk cycles
    localparam int unsigned wr_low_default  = 2;
    localparam int unsigned wr_high_default = 2;

    // 480 x 800 panel
    localparam int unsigned fill_pixels_default = 384000;
    localparam int unsigned hold_cycles_default = 300000000; // roughly 5 s at 60 MHz
    localparam logic [15:0] bg_color_default    = 16'hffff;

    // register word addresses
    localparam logic [3:0] reg_status = 4'd0;
    localparam logic [3:0] reg_cmd    = 4'd1;
    localparam logic [3:0] reg_data   = 4'd2;
    localparam logic [3:0] reg_ctrl   = 4'd3;

    // status bits
    localparam int status_done_bit = 0;
    localparam int status_busy_bit = 1;

    localparam int ctrl_bl_bit = 0; // backlight enable

endpackage

// File: design/lcd_cmd_pkg.sv
package lcd_cmd_pkg;

    typedef enum logic [1:0] {
        seq_cmd,   // goes out with rs low
        seq_param, // rs high
        seq_pause  // no bus cycle, value x 256 idle cycles
    } seq_kind_t;

    typedef struct packed {
        seq_kind_t   kind;
        logic [15:0] value;
    } seq_entry_t;

    localparam int init_len = 18;

    localparam seq_entry_t init_table [init_len] = '{
        '{seq_cmd,   16'h0001}, // software reset
        '{seq_pause, 16'd8},
        '{seq_cmd,   16'h0011}, // sleep out
        '{seq_pause, 16'd16},
        '{seq_cmd,   16'h003a}, // pixel format
        '{seq_param, 16'h0055}, // 16 bpp
        '{seq_cmd,   16'h0029}, // display on
        '{seq_cmd,   16'h002a}, // column window 0..479
        '{seq_param, 16'h0000},
        '{seq_param, 16'h0000},
        '{seq_param, 16'h0001},
        '{seq_param, 16'h00df},
        '{seq_cmd,   16'h002b}, // page window 0..799
        '{seq_param, 16'h0000},
        '{seq_param, 16'h0000},
        '{seq_param, 16'h0003},
        '{seq_param, 16'h001f},
        '{seq_cmd,   16'h002c}  // memory write, fill follows
    };

endpackage

// File: design/lcd_init_seq.sv
`timescale 1ns/10ps

module lcd_init_seq #(
    parameter int unsigned fill_pixels = lcd_timing_pkg::fill_pixels_default,
    parameter int unsigned hold_cycles = lcd_timing_pkg::hold_cycles_default,
    parameter logic [15:0] bg_color    = lcd_timing_pkg::bg_color_default
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        accept,
    input  logic        done,
    output logic        req,
    output logic        rs,
    output logic [15:0] data,
    output logic        init_done,
    output logic        busy
);
    import lcd_cmd_pkg::*;

    localparam int idx_w = $clog2(init_len + 1);

    typedef enum logic [2:0] {
        st_entry, // pick the next table entry or fill pixel
        st_issue, // request held until accept
        st_wait,  // cycle in flight
        st_pause,
        st_hold,
        st_done
    } state_t;

    state_t           state;
    logic [idx_w-1:0] idx;
    logic [23:0]      pause_cnt;
    logic [31:0]      fill_cnt;
    logic [31:0]      hold_cnt;

    assign busy = (state != st_done);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= st_entry;
            idx       <= '0;
            pause_cnt <= '0;
            fill_cnt  <= '0;
            hold_cnt  <= '0;
            req       <= 1'b0;
            rs        <= 1'b0;
            data      <= '0;
            init_done <= 1'b0;
        end else begin
            case (state)
                st_entry: begin
                    if (idx < init_len) begin
                        if (init_table[idx].kind == seq_pause) begin
                            pause_cnt <= {init_table[idx].value, 8'h00};
                            state     <= st_pause;
                        end else begin
                            req   <= 1'b1;
                            rs    <= (init_table[idx].kind == seq_param);
                            data  <= init_table[idx].value;
                            state <= st_issue;
                        end
                    end else if (fill_cnt < fill_pixels) begin
                        // background pixels go out as data
                        req   <= 1'b1;
                        rs    <= 1'b1;
                        data  <= bg_color;
                        state <= st_issue;
                    end else begin
                        hold_cnt <= '0;
                        state    <= st_hold;
                    end
                end

                st_issue: begin
                    if (accept) begin
                        req   <= 1'b0;
                        state <= st_wait;
                    end
                end

                st_wait: begin
                    if (done) begin
                        if (idx < init_len)
                            idx <= idx + 1'b1;
                        else
                            fill_cnt <= fill_cnt + 1'b1;
                        state <= st_entry;
                    end
                end

                st_pause: begin
                    if (pause_cnt <= 24'd1) begin
                        idx   <= idx + 1'b1;
                        state <= st_entry;
                    end else begin
                        pause_cnt <= pause_cnt - 1'b1;
                    end
                end

                st_hold: begin
                    // let the panel settle before the host takes over
                    if (hold_cnt >= hold_cycles) begin
                        init_done <= 1'b1;
                        state     <= st_done;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end

                st_done: begin
                    req <= 1'b0; // sequencer stays silent until reset
                end

                default: begin
                    state <= st_entry;
                end
            endcase
        end
    end

    // once done, the bus belongs to the host only
    a_no_req_after_done: assert property (
        @(posedge pclk) disable iff (!rst_n)
        init_done |-> !req
    );

endmodule

// File: design/lcd_bus_writer.sv
`timescale 1ns/10ps

module lcd_bus_writer #(
    parameter int unsigned wr_low  = lcd_timing_pkg::wr_low_default,
    parameter int unsigned wr_high = lcd_timing_pkg::wr_high_default
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        seq_req,
    input  logic        seq_rs,
    input  logic [15:0] seq_data,
    input  logic        host_req,
    input  logic        host_rs,
    input  logic [15:0] host_data,
    output logic        seq_accept,
    output logic        host_accept,
    output logic        done,
    output logic        cs_n,
    output logic        wr_n,
    output logic        rs,
    output logic [15:0] data
);

    localparam int unsigned cnt_max = (wr_low > wr_high) ? wr_low : wr_high;
    localparam int cnt_w = $clog2(cnt_max + 1);

    typedef enum logic [1:0] {ph_idle, ph_low, ph_high} phase_t;

    phase_t           phase;
    logic [cnt_w-1:0] cnt;
    logic             take_seq;
    logic             take_host;

    // sequencer has priority, host fills the gaps
    assign take_seq  = (phase == ph_idle) && seq_req;
    assign take_host = (phase == ph_idle) && host_req && !seq_req;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            phase       <= ph_idle;
            cnt         <= '0;
            cs_n        <= 1'b1;
            wr_n        <= 1'b1;
            seq_accept  <= 1'b0;
            host_accept <= 1'b0;
            done        <= 1'b0;
        end else begin
            seq_accept  <= take_seq;
            host_accept <= take_host;
            done        <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (take_seq || take_host) begin
                        cs_n  <= 1'b0;
                        wr_n  <= 1'b0;
                        cnt   <= cnt_w'(wr_low - 1);
                        phase <= ph_low;
                    end
                end
                ph_low: begin
                    if (cnt == '0) begin
                        wr_n  <= 1'b1; // panel samples here
                        cnt   <= cnt_w'(wr_high - 1);
                        phase <= ph_high;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ph_high: begin
                    if (cnt == '0) begin
                        cs_n  <= 1'b1;
                        done  <= 1'b1;
                        phase <= ph_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    // winner's rs and data held for the whole cycle
    always_ff @(posedge pclk) begin
        if (take_seq) begin
            rs   <= seq_rs;
            data <= seq_data;
        end else if (take_host) begin
            rs   <= host_rs;
            data <= host_data;
        end
    end

    a_wr_inside_cs: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !wr_n |-> !cs_n
    );

    a_one_accept: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !(seq_accept && host_accept)
    );

endmodule

// File: design/lcd_wb_regs.sv
`timescale 1ns/10ps

module lcd_wb_regs (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [15:0] wb_dat_w,
    input  logic        init_done,
    input  logic        seq_busy,
    input  logic        host_accept,
    input  logic        done,
    output logic        wb_ack,
    output logic [15:0] wb_dat_r,
    output logic        host_req,
    output logic        host_rs,
    output logic [15:0] host_data,
    output logic        backlight
);
    import lcd_timing_pkg::*;

    logic        ack_q;
    logic        host_inflight;
    logic        is_host_wr;
    logic        simple_acc;
    logic        start_host;
    logic        busy;
    logic [15:0] rd_val;

    assign is_host_wr = wb_we && ((wb_adr == reg_cmd) || (wb_adr == reg_data));
    assign simple_acc = wb_cyc && wb_stb && !is_host_wr && !ack_q;
    assign start_host = wb_cyc && wb_stb && is_host_wr && !host_req;

    assign busy = host_req || host_inflight || seq_busy;

    // panel writes stall the bus until the writer takes them
    assign wb_ack = ack_q || host_accept;

    always_comb begin
        rd_val = '0;
        if (wb_adr == reg_status) begin
            rd_val[status_done_bit] = init_done;
            rd_val[status_busy_bit] = busy;
        end else if (wb_adr == reg_ctrl) begin
            rd_val[ctrl_bl_bit] = backlight;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            ack_q         <= 1'b0;
            host_req      <= 1'b0;
            host_inflight <= 1'b0;
            backlight     <= 1'b0;
        end else begin
            ack_q <= simple_acc;
            if (simple_acc && wb_we && (wb_adr == reg_ctrl))
                backlight <= wb_dat_w[ctrl_bl_bit];
            if (start_host)
                host_req <= 1'b1;
            else if (host_accept)
                host_req <= 1'b0;
            if (host_accept)
                host_inflight <= 1'b1;
            else if (done)
                host_inflight <= 1'b0; // one cycle in flight at a time
        end
    end

    always_ff @(posedge pclk) begin
        if (simple_acc)
            wb_dat_r <= rd_val;
        if (start_host) begin
            host_rs   <= (wb_adr == reg_data);
            host_data <= wb_dat_w;
        end
    end

    a_ack_in_cycle: assert property (
        @(posedge pclk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

// File: design/lcd_ctrl_top.sv
`timescale 1ns/10ps

module lcd_ctrl_top #(
    parameter int unsigned wr_low      = lcd_timing_pkg::wr_low_default,
    parameter int unsigned wr_high     = lcd_timing_pkg::wr_high_default,
    parameter int unsigned fill_pixels = lcd_timing_pkg::fill_pixels_default,
    parameter int unsigned hold_cycles = lcd_timing_pkg::hold_cycles_default,
    parameter logic [15:0] bg_color    = lcd_timing_pkg::bg_color_default
) (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic        wb_ack,
    output logic [15:0] wb_dat_r,
    output logic        lcd_cs_n,
    output logic        lcd_wr_n,
    output logic        lcd_rs,
    output logic [15:0] lcd_data,
    output logic        lcd_bl
);

    logic        seq_req;
    logic        seq_rs;
    logic [15:0] seq_data;
    logic        seq_accept;
    logic        seq_busy;
    logic        init_done;
    logic        host_req;
    logic        host_rs;
    logic [15:0] host_data;
    logic        host_accept;
    logic        wr_done; // shared end-of-cycle pulse

    lcd_init_seq #(
        .fill_pixels (fill_pixels),
        .hold_cycles (hold_cycles),
        .bg_color    (bg_color)
    ) u_seq (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .accept    (seq_accept),
        .done      (wr_done),
        .req       (seq_req),
        .rs        (seq_rs),
        .data      (seq_data),
        .init_done (init_done),
        .busy      (seq_busy)
    );

    lcd_bus_writer #(
        .wr_low  (wr_low),
        .wr_high (wr_high)
    ) u_writer (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .seq_req     (seq_req),
        .seq_rs      (seq_rs),
        .seq_data    (seq_data),
        .host_req    (host_req),
        .host_rs     (host_rs),
        .host_data   (host_data),
        .seq_accept  (seq_accept),
        .host_accept (host_accept),
        .done        (wr_done),
        .cs_n        (lcd_cs_n),
        .wr_n        (lcd_wr_n),
        .rs          (lcd_rs),
        .data        (lcd_data)
    );

    lcd_wb_regs u_regs (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .init_done   (init_done),
        .seq_busy    (seq_busy),
        .host_accept (host_accept),
        .done        (wr_done),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .host_req    (host_req),
        .host_rs     (host_rs),
        .host_data   (host_data),
        .backlight   (lcd_bl)
    );

endmodule

// File: sim/lcd_panel_model.sv
`timescale 1ns/10ps

module lcd_panel_model (
    input logic        cs_n,
    input logic        wr_n,
    input logic        rs,
    input logic [15:0] data
);

    // captured writes, {rs, data}
    logic [16:0] cap_q [$];

    // panel latches rs and data on the rising strobe
    always @(posedge wr_n) begin
        if (cs_n === 1'b0) begin // ignore the X to 1 edge at reset
            cap_q.push_back({rs, data});
        end
    end

endmodule

// File: sim/lcd_ctrl_tb.sv
`timescale 1ns/10ps

module lcd_ctrl_tb;
    import lcd_timing_pkg::*;
    import lcd_cmd_pkg::*;

    localparam int fill_n     = 8;
    localparam int hold_n     = 50;
    localparam int wb_timeout = 100; // cycles

    logic        pclk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic        wb_ack;
    logic [15:0] wb_dat_r;
    logic        lcd_cs_n;
    logic        lcd_wr_n;
    logic        lcd_rs;
    logic [15:0] lcd_data;
    logic        lcd_bl;

    integer seed;
    int     check_cnt;
    int     err_cnt;

    lcd_ctrl_top #(
        .fill_pixels (fill_n),
        .hold_cycles (hold_n)
    ) UUT (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .lcd_cs_n (lcd_cs_n),
        .lcd_wr_n (lcd_wr_n),
        .lcd_rs   (lcd_rs),
        .lcd_data (lcd_data),
        .lcd_bl   (lcd_bl)
    );

    lcd_panel_model u_panel (
        .cs_n (lcd_cs_n),
        .wr_n (lcd_wr_n),
        .rs   (lcd_rs),
        .data (lcd_data)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
        check_cnt++;
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d error(s)", name, err_cnt - errs_before);
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [15:0] dat);
        int n;
        n = 0;
        @(negedge pclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge pclk);
        while (!wb_ack && n < wb_timeout) begin
            @(negedge pclk);
            n++;
        end
        if (!wb_ack) begin
            $display("Error: no ack on write to address %0d at %0t", adr, $time);
            err_cnt++;
        end else begin
            @(negedge pclk); // hold past the ack edge
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [15:0] dat);
        int n;
        n = 0;
        @(negedge pclk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge pclk);
        while (!wb_ack && n < wb_timeout) begin
            @(negedge pclk);
            n++;
        end
        dat = wb_dat_r;
        if (!wb_ack) begin
            $display("Error: no ack on read from address %0d at %0t", adr, $time);
            err_cnt++;
        end else begin
            @(negedge pclk); // hold past the ack edge
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_captures(input int count, input int limit);
        int n;
        n = 0;
        while (u_panel.cap_q.size() < count && n < limit) begin
            @(negedge pclk);
            n++;
        end
        if (u_panel.cap_q.size() < count) begin
            $display("Error: timed out waiting for %0d panel writes, saw %0d",
                     count, u_panel.cap_q.size());
            err_cnt++;
        end
    endtask

    task automatic take_capture(output logic [16:0] cap);
        if (u_panel.cap_q.size() == 0) begin
            $display("Error: panel received fewer writes than expected at %0t", $time);
            err_cnt++;
            cap = '0;
        end else begin
            cap = u_panel.cap_q.pop_front();
        end
    endtask

    task automatic reset_state();
        logic [15:0] rd;
        int          errs0;
        errs0 = err_cnt;
        repeat (10) @(negedge pclk);
        check_val(lcd_cs_n, 1'b1, "cs_n in reset");
        check_val(lcd_wr_n, 1'b1, "wr_n in reset");
        check_val(lcd_bl, 1'b0, "backlight in reset");
        rst_n = 1'b1;
        wb_read(reg_status, rd);
        check_val(rd[status_done_bit], 1'b0, "init done right after reset");
        check_val(rd[status_busy_bit], 1'b1, "busy while the sequencer runs");
        report_test("reset state", errs0);
    endtask

    task automatic table_playback();
        logic [16:0] got;
        int          i;
        int          n_exp;
        int          errs0;
        errs0 = err_cnt;
        n_exp = 0;
        for (i = 0; i < init_len; i++) begin
            if (init_table[i].kind != seq_pause)
                n_exp++;
        end
        wait_captures(n_exp, 20000); // pauses take a few thousand cycles
        for (i = 0; i < init_len; i++) begin
            if (init_table[i].kind != seq_pause) begin
                take_capture(got);
                check_val(got[16], init_table[i].kind == seq_param,
                          $sformatf("rs of table entry %0d", i));
                check_val(got[15:0], init_table[i].value,
                          $sformatf("data of table entry %0d", i));
            end
        end
        report_test("init table playback", errs0);
    endtask

    task automatic background_fill();
        logic [16:0] got;
        logic [15:0] rd;
        int          i;
        int          polls;
        int          errs0;
        errs0 = err_cnt;
        wait_captures(fill_n, 2000);
        for (i = 0; i < fill_n; i++) begin
            take_capture(got);
            check_val(got[16], 1'b1, $sformatf("rs of fill pixel %0d", i));
            check_val(got[15:0], bg_color_default, $sformatf("colour of fill pixel %0d", i));
        end
        rd    = '0;
        polls = 0;
        while (!rd[status_done_bit] && polls < 200) begin
            wb_read(reg_status, rd);
            polls++;
        end
        if (!rd[status_done_bit]) begin
            $display("Error: init done never set after %0d status reads", polls);
            err_cnt++;
        end
        check_val(rd[status_busy_bit], 1'b0, "busy after init");
        check_val(u_panel.cap_q.size(), 0, "panel writes beyond the fill");
        report_test("background fill", errs0);
    endtask

    task automatic host_writes();
        logic [16:0] exp_q [$];
        logic [16:0] got;
        logic [16:0] exp_v;
        logic [15:0] val;
        int          i;
        int          errs0;
        errs0 = err_cnt;
        for (i = 0; i < 4; i++) begin
            val = $random(seed);
            wb_write(reg_cmd, val);
            exp_q.push_back({1'b0, val});
            val = $random(seed);
            wb_write(reg_data, val);
            exp_q.push_back({1'b1, val});
        end
        wait_captures(exp_q.size(), 500);
        i = 0;
        while (exp_q.size() > 0) begin
            exp_v = exp_q.pop_front();
            take_capture(got);
            check_val(got, exp_v, $sformatf("host write %0d", i));
            i++;
        end
        report_test("host command and data writes", errs0);
    endtask

    task automatic ctrl_and_unmapped();
        logic [15:0] rd;
        int          errs0;
        errs0 = err_cnt;
        wb_write(reg_ctrl, 16'h0001 << ctrl_bl_bit);
        wb_read(reg_ctrl, rd);
        check_val(rd[ctrl_bl_bit], 1'b1, "backlight bit readback");
        check_val(lcd_bl, 1'b1, "lcd_bl after set");
        wb_write(reg_ctrl, 16'h0000);
        check_val(lcd_bl, 1'b0, "lcd_bl after clear");
        wb_read(4'h9, rd); // nothing mapped here
        check_val(rd, 16'h0000, "unmapped read");
        report_test("control and unmapped access", errs0);
    endtask

    initial begin
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        seed      = 28117;
        check_cnt = 0;
        err_cnt   = 0;

        reset_state();
        table_playback();
        background_fill();
        host_writes();
        ctrl_and_unmapped();

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
design/lcd_timing_pkg.sv
design/lcd_cmd_pkg.sv
design/lcd_init_seq.sv
design/lcd_bus_writer.sv
design/lcd_wb_regs.sv
design/lcd_ctrl_top.sv
sim/lcd_panel_model.sv
sim/lcd_ctrl_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - design/lcd_timing_pkg.sv
  - design/lcd_cmd_pkg.sv
  - design/lcd_init_seq.sv
  - design/lcd_bus_writer.sv
  - design/lcd_wb_regs.sv
  - design/lcd_ctrl_top.sv
  - target: simulation
    files:
      - sim/lcd_panel_model.sv
      - sim/lcd_ctrl_tb.sv
